/* flist.f */
+incdir+design
+incdir+verif
design/pit_pkg.sv
design/pit_control_regs.sv
design/pit_count_engine.sv
design/pit_readback.sv
design/pit_counter.sv
verif/pit_counter_tb.sv

/* verif/pit_model.svh */
// Reference model of one PIT counter channel in modes 0 and 2
// Tracks the expected count and output over counter clock falling edges

`ifndef PIT_MODEL_SVH
`define PIT_MODEL_SVH

count_t exp_count;
count_t exp_preset;
logic   exp_out;
logic   exp_rate;
logic   exp_pending;
logic   exp_restart;
logic   exp_gate;

// Other byte is zero in single-byte formats, zero means 65536
function automatic count_t zero_filled_preset(rw_select_t fmt, logic [7:0] lsb, logic [7:0] msb);
    logic [15:0] value;
    case (fmt)
        RW_MSB:  value = {msb, 8'h00};
        RW_LSB:  value = {8'h00, lsb};
        default: value = {msb, lsb};
    endcase
    return (value == 16'd0) ? count_t'(17'h10000) : count_t'(value);
endfunction

task automatic configure_expected(input logic rate);
    exp_rate    = rate;
    exp_count   = '0;
    exp_out     = rate;
    exp_pending = 1'b0;
    exp_restart = 1'b0;
endtask

task automatic load_expected_preset(input count_t preset);
    exp_preset  = preset;
    exp_pending = 1'b1;
endtask

task automatic gate_expected(input logic gate);
    if (exp_rate && !gate) begin
        exp_out = 1'b1;
    end
    if (exp_rate && gate && !exp_gate) begin
        exp_restart = 1'b1;
    end
    exp_gate = gate;
endtask

// One falling edge of the counter clock
task automatic advance_expected();
    if (exp_rate) begin
        if (!exp_gate) begin
            exp_out = 1'b1;
        end else if (exp_restart || (exp_count <= 1)) begin
            exp_count   = exp_preset;
            exp_restart = 1'b0;
            exp_out     = 1'b1;
        end else begin
            exp_count = exp_count - 1;
            exp_out   = (exp_count != 1);
        end
    end else begin
        if (exp_pending) begin
            exp_count   = exp_preset;
            exp_pending = 1'b0;
        end else if (exp_gate && (exp_count != 0)) begin
            exp_count = exp_count - 1;
        end
        exp_out = (exp_count == 0);
    end
endtask

`endif

/* verif/pit_counter_tb.sv */
// Testbench for the PIT counter channel
// Random presets in modes 0 and 2, gate control and latched reads against a model

`timescale 1ns/10ps

module pit_counter_tb;

    import pit_pkg::*;

    `include "pit_model.svh"

    logic       clock;
    logic       reset;
    logic [7:0] data_in;
    logic       write_control;
    logic       write_counter;
    logic       read_counter;
    logic [7:0] read_data;
    logic       counter_clock;
    logic       counter_gate;
    logic       counter_out;

    integer     seed;
    integer     error_count;
    integer     timeout_count;
    integer     edge_index;
    integer     lows;
    integer     gap;
    logic [7:0] lsb;
    logic [7:0] msb;
    count_t     preset;
    count_t     latched_value;
    rw_select_t fmt;

    pit_counter pit_counter_inst (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .write_control (write_control),
        .write_counter (write_counter),
        .read_counter  (read_counter),
        .read_data     (read_data),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .counter_out   (counter_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic wait_clocks(input integer n);
        repeat (n) @(posedge clock);
    endtask

    task automatic check_equal(input string name, input integer expected, input integer actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string name);
        timeout_count = timeout_count + 1;
        $display("Timeout in %s: counter output never changed as expected", name);
    endtask

    task automatic strobe_byte(input logic to_control, input logic [7:0] value);
        @(posedge clock);
        data_in <= value;
        if (to_control) begin
            write_control <= 1'b1;
        end else begin
            write_counter <= 1'b1;
        end
        @(posedge clock);
        write_control <= 1'b0;
        write_counter <= 1'b0;
    endtask

    task automatic configure(input rw_select_t rw, input logic rate);
        strobe_byte(1'b1, {2'b00, rw, (rate ? 3'd2 : 3'd0), 1'b0});
        configure_expected(rate);
        wait_clocks(2);
        @(negedge clock);
        check_equal("idle output", exp_out, counter_out);
    endtask

    // Two-byte format writes LSB first
    task automatic write_preset(input rw_select_t rw, input logic [7:0] lo, input logic [7:0] hi);
        if (rw != RW_MSB) begin
            strobe_byte(1'b0, lo);
        end
        if (rw != RW_LSB) begin
            strobe_byte(1'b0, hi);
        end
        load_expected_preset(zero_filled_preset(rw, lo, hi));
        edge_index = 0;
    endtask

    task automatic read_byte(output logic [7:0] value);
        @(posedge clock);
        read_counter <= 1'b1;
        @(negedge clock);
        value = read_data;
        @(posedge clock);
        read_counter <= 1'b0;
        wait_clocks(2);
    endtask

    task automatic drive_gate(input logic level);
        @(posedge clock);
        counter_gate <= level;
        gate_expected(level);
        wait_clocks(2);
        @(negedge clock);
        check_equal("gate output", exp_out, counter_out);
    endtask

    // Full counter clock period, falling edge first, output checked after it
    task automatic counter_period(input string name);
        @(posedge clock);
        counter_clock <= 1'b0;
        wait_clocks(8);
        counter_clock <= 1'b1;
        wait_clocks(7);
        @(negedge clock);
        advance_expected();
        edge_index = edge_index + 1;
        check_equal(name, exp_out, counter_out);
    endtask

    task automatic run_to_terminal(input string name, input integer expected_edge);
        while ((counter_out !== 1'b1) && (edge_index < expected_edge + 8)) begin
            counter_period(name);
        end
        if (counter_out !== 1'b1) begin
            report_timeout(name);
        end else begin
            check_equal(name, expected_edge, edge_index);
        end
    endtask

    // Edges from a rising gate until the rate output next goes low
    task automatic check_restart(input string name, input integer period);
        edge_index = 0;
        while ((counter_out !== 1'b0) && (edge_index < period + 4)) begin
            counter_period(name);
        end
        if (counter_out !== 1'b0) begin
            report_timeout(name);
        end else begin
            check_equal(name, period, edge_index);
        end
    endtask

    initial begin
        seed          = 43860;
        error_count   = 0;
        timeout_count = 0;
        edge_index    = 0;
        reset         = 1'b1;
        data_in       = 8'h00;
        write_control = 1'b0;
        write_counter = 1'b0;
        read_counter  = 1'b0;
        counter_clock = 1'b1;
        counter_gate  = 1'b1;
        exp_gate      = 1'b1;
        configure_expected(1'b0);
        wait_clocks(16);
        reset <= 1'b0;
        wait_clocks(2);
        @(negedge clock);
        check_equal("reset output", 0, counter_out);
        check_equal("reset read data", 0, read_data);

        for (int f = 0; f < 3; f++) begin
            fmt = (f == 0) ? RW_LSB : ((f == 1) ? RW_MSB : RW_BOTH);
            lsb = 8'($unsigned($random(seed)) % 39 + 2);
            msb = 8'($unsigned($random(seed)) % 39 + 2);
            if (fmt == RW_BOTH) begin
                msb = 8'($unsigned($random(seed)) % 2);
            end
            configure(fmt, 1'b0);
            write_preset(fmt, lsb, msb);
            preset = zero_filled_preset(fmt, lsb, msb);
            run_to_terminal($sformatf("mode 0 format %0d", f), preset + 1);
        end

        // Terminal edge moves later by the number of edges with the gate low
        lsb = 8'($unsigned($random(seed)) % 31 + 10);
        configure(RW_LSB, 1'b0);
        write_preset(RW_LSB, lsb, 8'd0);
        counter_period("gate hold");
        counter_period("gate hold");
        drive_gate(1'b0);
        gap = $unsigned($random(seed)) % 8 + 1;
        repeat (gap) counter_period("gate hold");
        drive_gate(1'b1);
        run_to_terminal("gate hold", lsb + 1 + gap);

        lsb = 8'($unsigned($random(seed)) % 39 + 2);
        configure(RW_LSB, 1'b1);
        write_preset(RW_LSB, lsb, 8'd0);
        lows = 0;
        repeat (3 * lsb) begin
            counter_period("rate output");
            if (counter_out === 1'b0) begin
                lows = lows + 1;
            end
        end
        check_equal("rate low periods", 3, lows);
        drive_gate(1'b0);
        counter_period("rate gate low");
        counter_period("rate gate low");
        drive_gate(1'b1);
        check_restart("rate restart", lsb);
        // Gate dropped at the top of the count, where a plain decrement ends early
        counter_period("rate output");
        drive_gate(1'b0);
        counter_period("rate gate low");
        drive_gate(1'b1);
        check_restart("rate restart mid count", lsb);

        lsb = 8'($unsigned($random(seed)) % 39 + 2);
        configure(RW_BOTH, 1'b0);
        write_preset(RW_BOTH, lsb, 8'd1);
        repeat ($unsigned($random(seed)) % 8 + 2) counter_period("latch count");
        strobe_byte(1'b1, 8'h00);
        latched_value = exp_count;
        counter_period("latch count");
        counter_period("latch count");
        read_byte(lsb);
        read_byte(msb);
        check_equal("latched read", latched_value[15:0], {msb, lsb});
        read_byte(lsb);
        read_byte(msb);
        check_equal("live read", exp_count[15:0], {msb, lsb});
        if ({msb, lsb} === latched_value[15:0]) begin
            error_count = error_count + 1;
            $display("Live count did not move after the latched read");
        end

        $display("Run complete: %0d value errors, %0d timeouts", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/pit_counter.sv */
// PIT counter channel
// One 8253-style counter with modes 0 and 2, gate control and count latch

`timescale 1ns/10ps

module pit_counter (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       write_control,
    input  logic       write_counter,
    input  logic       read_counter,
    output logic [7:0] read_data,
    input  logic       counter_clock,
    input  logic       counter_gate,
    output logic       counter_out
);

    import pit_pkg::*;

    rw_select_t    rw_select;
    counter_mode_t mode;
    count_t        preset_load;
    count_t        count;
    logic          count_armed;
    logic          config_write;
    logic          latch_command;

    pit_control_regs pit_control_regs_inst (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .write_control (write_control),
        .write_counter (write_counter),
        .rw_select     (rw_select),
        .mode          (mode),
        .preset_load   (preset_load),
        .count_armed   (count_armed),
        .config_write  (config_write),
        .latch_command (latch_command)
    );

    pit_count_engine pit_count_engine_inst (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .write_counter (write_counter),
        .count_armed   (count_armed),
        .mode          (mode),
        .preset_load   (preset_load),
        .count         (count),
        .counter_out   (counter_out)
    );

    pit_readback pit_readback_inst (
        .clock         (clock),
        .reset         (reset),
        .rw_select     (rw_select),
        .config_write  (config_write),
        .latch_command (latch_command),
        .read_counter  (read_counter),
        .count         (count),
        .read_data     (read_data)
    );

endmodule

/* design/pit_readback.sv */
// PIT readback path
// Holds the count for the host, freezes it on a latch command
// and steps through the bytes of the read format

`timescale 1ns/10ps

`include "pit_defines.svh"

module pit_readback (
    input  logic                        clock,
    input  logic                        reset,
    input  pit_pkg::rw_select_t         rw_select,
    input  logic                        config_write,
    input  logic                        latch_command,
    input  logic                        read_counter,
    input  pit_pkg::count_t             count,
    output logic [`PIT_BYTE_WIDTH-1:0]  read_data
);

    import pit_pkg::*;

    count_t count_hold;
    logic   latched;
    logic   read_prev;
    logic   read_fall;
    logic   read_msb_next;
    logic   last_byte;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_prev <= 1'b0;
        end else begin
            read_prev <= read_counter;
        end
    end

    assign read_fall = read_prev && !read_counter;
    assign last_byte = (rw_select != RW_BOTH) || read_msb_next;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_msb_next <= 1'b0;
        end else if (config_write) begin
            read_msb_next <= 1'b0;
        end else if (read_fall && (rw_select == RW_BOTH)) begin
            read_msb_next <= ~read_msb_next;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            latched <= 1'b0;
        end else if (latch_command) begin
            latched <= 1'b1;
        end else if (read_fall && last_byte) begin
            latched <= 1'b0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count_hold <= '0;
        end else if (!latched) begin
            count_hold <= count;
        end
    end

    assign read_data = ((rw_select == RW_MSB) || (rw_select == RW_BOTH && read_msb_next)) ?
                       count_hold[2*`PIT_BYTE_WIDTH-1:`PIT_BYTE_WIDTH] :
                       count_hold[`PIT_BYTE_WIDTH-1:0];

    single_byte_step: assert property (
        @(posedge clock) disable iff (reset)
        (rw_select != RW_BOTH) |-> !read_msb_next
    );

endmodule

/* design/pit_count_engine.sv */
// PIT count engine
// Samples the counter clock and gate, runs the down counter and
// drives the counter output for interrupt on terminal count and rate generator

`timescale 1ns/10ps

module pit_count_engine (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   counter_clock,
    input  logic                   counter_gate,
    input  logic                   write_counter,
    input  logic                   count_armed,
    input  pit_pkg::counter_mode_t mode,
    input  pit_pkg::count_t        preset_load,
    output pit_pkg::count_t        count,
    output logic                   counter_out
);

    import pit_pkg::*;

    logic   clock_prev;
    logic   count_edge;
    logic   gate_seen;
    logic   gate_rise;
    logic   load_pending;
    count_t count_dec;
    count_t count_next;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            clock_prev <= 1'b0;
        end else begin
            clock_prev <= counter_clock;
        end
    end

    assign count_edge = clock_prev && !counter_clock;

    // A falling gate is tracked at once, a rising gate waits for the next edge
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            gate_seen <= 1'b0;
        end else if (count_edge || gate_seen) begin
            gate_seen <= counter_gate;
        end
    end

    assign gate_rise = counter_gate && !gate_seen;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else if (write_counter) begin
            load_pending <= 1'b1;
        end else if (count_edge) begin
            load_pending <= 1'b0;
        end
    end

    always_comb begin
        count_dec  = (count == '0) ? '0 : count - 1'b1;
        count_next = counter_gate ? count_dec : count;
        if (mode == MODE_RATE) begin
            if (counter_gate && (gate_rise || (count_dec == '0))) begin
                count_next = preset_load;
            end
        end else if (load_pending) begin
            count_next = preset_load;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!count_armed) begin
            count <= '0;
        end else if (count_edge) begin
            count <= count_next;
        end
    end

    // Rate generator pulses low while the count is 1
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counter_out <= 1'b0;
        end else if (!count_armed) begin
            counter_out <= (mode == MODE_RATE);
        end else if (mode == MODE_RATE) begin
            if (!counter_gate || !gate_seen) begin
                counter_out <= 1'b1;
            end else if (count_edge) begin
                counter_out <= (count_next != count_t'(1));
            end
        end else if (count_edge) begin
            counter_out <= (count_next == '0);
        end
    end

    terminal_out_holds: assert property (
        @(posedge clock) disable iff (reset)
        (mode == MODE_TERMINAL && count_armed && $past(count_armed) && $fell(counter_out))
        |-> $past(load_pending)
    );

endmodule

/* design/pit_control_regs.sv */
// PIT control register block
// Decodes control words, holds the read/load format and mode,
// assembles the preset bytes and arms the count engine

`timescale 1ns/10ps

`include "pit_defines.svh"

module pit_control_regs (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`PIT_BYTE_WIDTH-1:0] data_in,
    input  logic                       write_control,
    input  logic                       write_counter,
    output pit_pkg::rw_select_t        rw_select,
    output pit_pkg::counter_mode_t     mode,
    output pit_pkg::count_t            preset_load,
    output logic                       count_armed,
    output logic                       config_write,
    output logic                       latch_command
);

    import pit_pkg::*;

    logic [1:0]                     rl_field;
    logic [2:0]                     mode_field;
    logic [2*`PIT_BYTE_WIDTH-1:0]   preset;
    logic                           write_msb_next;
    logic                           write_to_msb;
    logic                           preset_done;

    assign rl_field   = data_in[`PIT_RL_LSB +: 2];
    assign mode_field = data_in[`PIT_MODE_LSB +: 3];

    assign latch_command = write_control && (rl_field == `PIT_RL_LATCH);
    assign config_write  = write_control && (rl_field != `PIT_RL_LATCH);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rw_select <= RW_MSB;
        end else if (config_write) begin
            rw_select <= rw_select_t'(rl_field);
        end
    end

    // Only mode 2 is special, everything else counts as mode 0
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mode <= MODE_TERMINAL;
        end else if (config_write) begin
            case (mode_field)
                `PIT_MODE_RATE:     mode <= MODE_RATE;
                `PIT_MODE_TERMINAL: mode <= MODE_TERMINAL;
                default:            mode <= MODE_TERMINAL;
            endcase
        end
    end

    // Byte order in two-byte format is LSB first
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_msb_next <= 1'b0;
        end else if (config_write) begin
            write_msb_next <= 1'b0;
        end else if (write_counter && (rw_select == RW_BOTH)) begin
            write_msb_next <= ~write_msb_next;
        end
    end

    assign write_to_msb = (rw_select == RW_MSB) ||
                          ((rw_select == RW_BOTH) && write_msb_next);
    assign preset_done  = (rw_select != RW_BOTH) || write_msb_next;

    always_ff @(posedge clock) begin
        if (write_counter) begin
            if (write_to_msb) begin
                preset[2*`PIT_BYTE_WIDTH-1:`PIT_BYTE_WIDTH] <= data_in;
            end else begin
                preset[`PIT_BYTE_WIDTH-1:0] <= data_in;
            end
        end
    end

    // Single-byte formats leave the other byte at zero
    always_comb begin
        case (rw_select)
            RW_MSB: begin
                preset_load[`PIT_COUNT_WIDTH-2:0] =
                    {preset[2*`PIT_BYTE_WIDTH-1:`PIT_BYTE_WIDTH], {`PIT_BYTE_WIDTH{1'b0}}};
            end
            RW_LSB: begin
                preset_load[`PIT_COUNT_WIDTH-2:0] =
                    {{`PIT_BYTE_WIDTH{1'b0}}, preset[`PIT_BYTE_WIDTH-1:0]};
            end
            default: begin
                preset_load[`PIT_COUNT_WIDTH-2:0] = preset;
            end
        endcase
        // Zero preset means 65536
        preset_load[`PIT_COUNT_WIDTH-1] = (preset_load[`PIT_COUNT_WIDTH-2:0] == '0);
    end

    // Mode 2 keeps running while a new LSB is written
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count_armed <= 1'b0;
        end else if (config_write) begin
            count_armed <= 1'b0;
        end else if (write_counter) begin
            if (preset_done) begin
                count_armed <= 1'b1;
            end else if (mode != MODE_RATE) begin
                count_armed <= 1'b0;
            end
        end
    end

    // Host sends a control word and a preset byte in separate cycles
    strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(write_control && write_counter)
    );

endmodule

/* design/pit_pkg.sv */
// PIT shared types
// Read/load format, counting mode and count value of one channel

`include "pit_defines.svh"

package pit_pkg;

    // Latch command is decoded separately and never stored
    typedef enum logic [1:0] {
        RW_MSB  = `PIT_RL_MSB,
        RW_LSB  = `PIT_RL_LSB_ONLY,
        RW_BOTH = `PIT_RL_BOTH
    } rw_select_t;

    typedef enum logic {
        MODE_TERMINAL = 1'b0,
        MODE_RATE     = 1'b1
    } counter_mode_t;

    typedef logic [`PIT_COUNT_WIDTH-1:0] count_t;

endpackage

/* design/pit_defines.svh */
// PIT field positions, read/load codes, mode codes and widths
// Shared by the package and the counter RTL

`ifndef PIT_DEFINES_SVH
`define PIT_DEFINES_SVH

// Count holds 16 bits plus the 65536 bit for a zero preset
`define PIT_COUNT_WIDTH 17
`define PIT_BYTE_WIDTH 8

// Control word field positions
`define PIT_RL_LSB 4
`define PIT_MODE_LSB 1

// Read/load field codes
`define PIT_RL_LATCH 2'd0
`define PIT_RL_MSB 2'd1
`define PIT_RL_LSB_ONLY 2'd2
`define PIT_RL_BOTH 2'd3

// Mode field codes
`define PIT_MODE_TERMINAL 3'd0
`define PIT_MODE_RATE 3'd2

`endif
